// ==== rtl/cnn_consts.svh ====
`ifndef CNN_CONSTS_SVH
`define CNN_CONSTS_SVH

// Vector sizes of the dense stage
`define CNN_IN_LEN      16
`define CNN_OUT_LEN     4

// Scratch RAM layout, weight row j at CNN_W_BASE + 16*j
`define CNN_RAM_DEPTH   88
`define CNN_IN_BASE     0
`define CNN_W_BASE      16
`define CNN_BIAS_BASE   80
`define CNN_OUT_BASE    84

// Remote file indices
`define CNN_FILE_IN     16'h0100
`define CNN_FILE_W      16'h0101
`define CNN_FILE_BIAS   16'h0102
`define CNN_FILE_OUT    16'h0200

// Transfer header bytes, 'R' and 'W'
`define CNN_HDR_READ    8'd82
`define CNN_HDR_WRITE   8'd87

`endif

// ==== rtl/cnn_pkg.sv ====
`include "cnn_consts.svh"

package cnn_pkg;

    typedef logic [7:0] byte_t;

    typedef logic [$clog2(`CNN_RAM_DEPTH)-1:0] ram_addr_t;

    // Filled as a word, sent high byte first
    typedef union packed {
        logic [15:0] word;
        struct packed {
            byte_t hi;
            byte_t lo;
        } bytes;
    } file_index_u;

    typedef struct packed {
        logic                        valid;
        logic                        write;
        file_index_u                 index;
        ram_addr_t                   base;
        logic [$bits(ram_addr_t)-1:0] count;
    } link_req_t;

    typedef struct packed {
        logic      en;
        ram_addr_t addr;
        byte_t     data;
    } ram_wr_t;

endpackage

// ==== rtl/file_link.sv ====
`timescale 1ns/10ps
`include "cnn_consts.svh"

module file_link (
    input  logic              clk,
    input  logic              reset,
    input  cnn_pkg::link_req_t req,
    output logic              done,
    input  cnn_pkg::byte_t    rx_data,
    input  logic              rx_rdy,
    output cnn_pkg::byte_t    tx_data,
    output logic              tx_en,
    input  logic              tx_busy,
    output cnn_pkg::ram_wr_t  wr,
    output cnn_pkg::ram_addr_t rd_addr,
    input  cnn_pkg::byte_t    rd_data
);
    import cnn_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_SEND_HDR,
        S_SEND_IDX,
        S_RECEIVE,
        S_SEND_DATA,
        S_SETTLE,
        S_WAIT_BUSY
    } state_t;

    state_t    state;
    state_t    ret_state;
    link_req_t req_q;
    ram_addr_t cnt;
    ram_addr_t cur_addr;

    assign cur_addr = req_q.base + cnt;
    assign rd_addr  = cur_addr;

    // Received bytes go straight into RAM
    always_comb begin
        wr.en   = (state == S_RECEIVE) && rx_rdy;
        wr.addr = cur_addr;
        wr.data = rx_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= S_IDLE;
            ret_state <= S_IDLE;
            cnt       <= '0;
            tx_en     <= 1'b0;
            done      <= 1'b0;
        end else begin
            tx_en <= 1'b0;
            done  <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (req.valid) begin
                        state <= S_SEND_HDR;
                    end
                end
                S_SEND_HDR: begin
                    tx_en     <= 1'b1;
                    cnt       <= '0;
                    ret_state <= S_SEND_IDX;
                    state     <= S_SETTLE;
                end
                S_SEND_IDX: begin
                    tx_en <= 1'b1;
                    state <= S_SETTLE;
                    if (cnt[0]) begin
                        cnt       <= '0;
                        ret_state <= req_q.write ? S_SEND_DATA : S_RECEIVE;
                    end else begin
                        cnt       <= cnt + 1'b1;
                        ret_state <= S_SEND_IDX;
                    end
                end
                S_RECEIVE: begin
                    if (rx_rdy) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == req_q.count - 1'b1) begin
                            done  <= 1'b1;
                            state <= S_IDLE;
                        end
                    end
                end
                S_SEND_DATA: begin
                    tx_en     <= 1'b1;
                    cnt       <= cnt + 1'b1;
                    ret_state <= (cnt == req_q.count - 1'b1) ? S_IDLE : S_SEND_DATA;
                    state     <= S_SETTLE;
                end
                // tx_busy is not valid until a cycle after tx_en
                S_SETTLE: begin
                    state <= S_WAIT_BUSY;
                end
                S_WAIT_BUSY: begin
                    if (!tx_busy) begin
                        state <= ret_state;
                        done  <= (ret_state == S_IDLE);
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req.valid) begin
            req_q <= req;
        end
        case (state)
            S_SEND_HDR:  tx_data <= req_q.write ? `CNN_HDR_WRITE : `CNN_HDR_READ;
            S_SEND_IDX:  tx_data <= cnt[0] ? req_q.index.bytes.lo : req_q.index.bytes.hi;
            S_SEND_DATA: tx_data <= rd_data;
            default:     tx_data <= tx_data;
        endcase
    end

    a_tx_en_idle: assert property (@(posedge clk) disable iff (reset)
        $rose(tx_en) |-> !tx_busy);

    a_wr_range: assert property (@(posedge clk) disable iff (reset)
        wr.en |-> (wr.addr < `CNN_RAM_DEPTH));

endmodule

// ==== rtl/scratch_ram.sv ====
`timescale 1ns/10ps
`include "cnn_consts.svh"

module scratch_ram (
    input  logic               clk,
    input  cnn_pkg::ram_wr_t   link_wr,
    input  cnn_pkg::ram_wr_t   calc_wr,
    input  cnn_pkg::ram_addr_t link_addr,
    input  cnn_pkg::ram_addr_t calc_addr,
    output cnn_pkg::byte_t     link_data,
    output cnn_pkg::byte_t     calc_data
);
    import cnn_pkg::*;

    byte_t mem [`CNN_RAM_DEPTH];

    always_ff @(posedge clk) begin
        if (link_wr.en) begin
            mem[link_wr.addr] <= link_wr.data;
        end
        if (calc_wr.en) begin
            mem[calc_wr.addr] <= calc_wr.data;
        end
    end

    assign link_data = mem[link_addr];
    assign calc_data = mem[calc_addr];

    // Link and dense stage own the RAM at different times
    a_one_writer: assert property (@(posedge clk) !(link_wr.en && calc_wr.en));

endmodule

// ==== rtl/dense_layer.sv ====
`timescale 1ns/10ps
`include "cnn_consts.svh"

module dense_layer (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    output logic               done,
    output cnn_pkg::ram_addr_t rd_addr,
    input  cnn_pkg::byte_t     rd_data,
    output cnn_pkg::ram_wr_t   wr
);
    import cnn_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_BIAS,
        S_FETCH_IN,
        S_FETCH_W,
        S_WRITE
    } state_t;

    state_t                              state;
    logic [$clog2(`CNN_IN_LEN)-1:0]      in_idx;
    logic [$clog2(`CNN_OUT_LEN)-1:0]     out_idx;
    byte_t                               acc;
    byte_t                               in_q;
    byte_t                               prod_q;

    // One read port, so each MAC step takes an input phase and a weight phase
    always_comb begin
        case (state)
            S_BIAS:    rd_addr = ram_addr_t'(`CNN_BIAS_BASE) + ram_addr_t'(out_idx);
            S_FETCH_W: rd_addr = ram_addr_t'(`CNN_W_BASE) + ram_addr_t'({out_idx, in_idx});
            default:   rd_addr = ram_addr_t'(`CNN_IN_BASE) + ram_addr_t'(in_idx);
        endcase
    end

    always_comb begin
        wr.en   = (state == S_WRITE);
        wr.addr = ram_addr_t'(`CNN_OUT_BASE) + ram_addr_t'(out_idx);
        wr.data = acc + prod_q;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= S_IDLE;
            in_idx  <= '0;
            out_idx <= '0;
            done    <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                S_IDLE: begin
                    out_idx <= '0;
                    if (start) begin
                        state <= S_BIAS;
                    end
                end
                S_BIAS: begin
                    in_idx <= '0;
                    state  <= S_FETCH_IN;
                end
                S_FETCH_IN: begin
                    state <= S_FETCH_W;
                end
                S_FETCH_W: begin
                    in_idx <= in_idx + 1'b1;
                    state  <= (in_idx == `CNN_IN_LEN - 1) ? S_WRITE : S_FETCH_IN;
                end
                S_WRITE: begin
                    out_idx <= out_idx + 1'b1;
                    if (out_idx == `CNN_OUT_LEN - 1) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        state <= S_BIAS;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Previous product is added while the next input is loaded
    always_ff @(posedge clk) begin
        case (state)
            S_BIAS: begin
                acc    <= rd_data;
                prod_q <= '0;
            end
            S_FETCH_IN: begin
                acc  <= acc + prod_q;
                in_q <= rd_data;
            end
            S_FETCH_W: begin
                prod_q <= in_q * rd_data;
            end
            default: begin
                acc <= acc;
            end
        endcase
    end

endmodule

// ==== rtl/layer_sequencer.sv ====
`timescale 1ns/10ps
`include "cnn_consts.svh"

module layer_sequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    output logic               busy,
    output logic               done,
    output cnn_pkg::link_req_t link_req,
    input  logic               link_done,
    output logic               calc_start,
    input  logic               calc_done
);
    import cnn_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_RD_IN,
        S_RD_W,
        S_RD_BIAS,
        S_CALC,
        S_WR_OUT
    } state_t;

    state_t state;

    function automatic link_req_t make_req(input logic write, input logic [15:0] file,
                                           input ram_addr_t base, input ram_addr_t count);
        link_req_t r;
        r.valid      = 1'b1;
        r.write      = write;
        r.index.word = file;
        r.base       = base;
        r.count      = count;
        return r;
    endfunction

    assign busy = (state != S_IDLE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= S_IDLE;
            link_req   <= '0;
            calc_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            link_req.valid <= 1'b0;
            calc_start     <= 1'b0;
            done           <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        link_req <= make_req(1'b0, `CNN_FILE_IN, ram_addr_t'(`CNN_IN_BASE),
                                             ram_addr_t'(`CNN_IN_LEN));
                        state    <= S_RD_IN;
                    end
                end
                S_RD_IN: begin
                    if (link_done) begin
                        link_req <= make_req(1'b0, `CNN_FILE_W, ram_addr_t'(`CNN_W_BASE),
                                             ram_addr_t'(`CNN_IN_LEN * `CNN_OUT_LEN));
                        state    <= S_RD_W;
                    end
                end
                S_RD_W: begin
                    if (link_done) begin
                        link_req <= make_req(1'b0, `CNN_FILE_BIAS, ram_addr_t'(`CNN_BIAS_BASE),
                                             ram_addr_t'(`CNN_OUT_LEN));
                        state    <= S_RD_BIAS;
                    end
                end
                S_RD_BIAS: begin
                    if (link_done) begin
                        calc_start <= 1'b1;
                        state      <= S_CALC;
                    end
                end
                S_CALC: begin
                    if (calc_done) begin
                        link_req <= make_req(1'b1, `CNN_FILE_OUT, ram_addr_t'(`CNN_OUT_BASE),
                                             ram_addr_t'(`CNN_OUT_LEN));
                        state    <= S_WR_OUT;
                    end
                end
                S_WR_OUT: begin
                    if (link_done) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // A start during a run must not restart the input read
    a_start_ignored: assert property (@(posedge clk) disable iff (reset)
        (start && busy) |=> !(link_req.valid && link_req.index.word == `CNN_FILE_IN));

endmodule

// ==== rtl/cnn_engine.sv ====
`timescale 1ns/10ps

module cnn_engine (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    output logic           busy,
    output logic           done,
    input  cnn_pkg::byte_t rx_data,
    input  logic           rx_rdy,
    output cnn_pkg::byte_t tx_data,
    output logic           tx_en,
    input  logic           tx_busy
);

    cnn_pkg::link_req_t link_req;
    logic               link_done;
    logic               calc_start;
    logic               calc_done;
    cnn_pkg::ram_wr_t   link_wr;
    cnn_pkg::ram_wr_t   calc_wr;
    cnn_pkg::ram_addr_t link_addr;
    cnn_pkg::ram_addr_t calc_addr;
    cnn_pkg::byte_t     link_data;
    cnn_pkg::byte_t     calc_data;

    layer_sequencer layer_sequencer_i (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .busy       (busy),
        .done       (done),
        .link_req   (link_req),
        .link_done  (link_done),
        .calc_start (calc_start),
        .calc_done  (calc_done)
    );

    file_link file_link_i (
        .clk     (clk),
        .reset   (reset),
        .req     (link_req),
        .done    (link_done),
        .rx_data (rx_data),
        .rx_rdy  (rx_rdy),
        .tx_data (tx_data),
        .tx_en   (tx_en),
        .tx_busy (tx_busy),
        .wr      (link_wr),
        .rd_addr (link_addr),
        .rd_data (link_data)
    );

    dense_layer dense_layer_i (
        .clk     (clk),
        .reset   (reset),
        .start   (calc_start),
        .done    (calc_done),
        .rd_addr (calc_addr),
        .rd_data (calc_data),
        .wr      (calc_wr)
    );

    scratch_ram scratch_ram_i (
        .clk       (clk),
        .link_wr   (link_wr),
        .calc_wr   (calc_wr),
        .link_addr (link_addr),
        .calc_addr (calc_addr),
        .link_data (link_data),
        .calc_data (calc_data)
    );

endmodule

// ==== tb/cnn_engine_tb.sv ====
`timescale 1ns/10ps
`include "cnn_consts.svh"

module cnn_engine_tb;
    import cnn_pkg::*;

    localparam int WAIT_LIMIT = 500;

    logic   clk;
    logic   reset;
    logic   start;
    logic   busy;
    logic   done;
    byte_t  rx_data;
    logic   rx_rdy;
    byte_t  tx_data;
    logic   tx_en;
    logic   tx_busy = 1'b0;

    int     errors = 0;
    int     overlap_count = 0;
    int     done_count = 0;
    int     busy_left = 0;
    bit     slow_tx = 1'b0;
    byte_t  tx_q[$];
    byte_t  file_data[$];
    byte_t  in_vec[`CNN_IN_LEN];
    byte_t  weights[`CNN_IN_LEN * `CNN_OUT_LEN];
    byte_t  biases[`CNN_OUT_LEN];

    cnn_engine cnn_engine_i (
        .clk     (clk),
        .reset   (reset),
        .start   (start),
        .busy    (busy),
        .done    (done),
        .rx_data (rx_data),
        .rx_rdy  (rx_rdy),
        .tx_data (tx_data),
        .tx_en   (tx_en),
        .tx_busy (tx_busy)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Transmitter model, busy from the cycle after tx_en
    always @(posedge clk) begin
        if (tx_en) begin
            tx_q.push_back(tx_data);
            if (tx_busy) begin
                $display("tx_en raised at %0t while tx_busy was still high", $time);
                overlap_count <= overlap_count + 1;
            end
            tx_busy   <= 1'b1;
            busy_left <= slow_tx ? 1 + int'($urandom % 8) : 1;
        end else if (busy_left > 1) begin
            busy_left <= busy_left - 1;
        end else begin
            tx_busy   <= 1'b0;
            busy_left <= 0;
        end
    end

    always @(posedge clk) begin
        if (done) begin
            done_count <= done_count + 1;
        end
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic wait_tx_bytes(input int n, input string what);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (tx_q.size() < n && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (tx_q.size() < n) begin
            $display("Timed out at %0t waiting for the %s to be sent", $time, what);
            errors++;
        end
    endtask

    task automatic wait_tx_idle;
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (tx_busy && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (tx_busy) begin
            $display("Timed out at %0t waiting for tx_busy to fall", $time);
            errors++;
        end
    endtask

    task automatic wait_done;
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            $display("Timed out at %0t waiting for done", $time);
            errors++;
        end
    endtask

    function automatic byte_t pop_tx();
        if (tx_q.size() == 0) begin
            return 8'hxx;
        end
        return tx_q.pop_front();
    endfunction

    // Bias plus the row's dot product, wrapping at 8 bits
    function automatic byte_t dense_sum(input int j);
        byte_t acc;
        acc = biases[j];
        for (int i = 0; i < `CNN_IN_LEN; i++) begin
            acc = acc + in_vec[i] * weights[j * `CNN_IN_LEN + i];
        end
        return acc;
    endfunction

    task automatic send_junk(input int n);
        int k;
        for (k = 0; k < n; k++) begin
            @(posedge clk);
            rx_data <= 8'($urandom);
            rx_rdy  <= 1'b1;
            @(posedge clk);
            rx_rdy  <= 1'b0;
        end
    endtask

    // Host side of one file transfer
    task automatic serve_transfer(input byte_t hdr, input logic [15:0] index, input int count,
                                  input bit junk);
        int i;
        wait_tx_bytes(1, "header byte");
        if (junk) begin
            send_junk(1);
        end
        wait_tx_bytes(3, "index bytes");
        check_value("tx header", 32'(hdr), 32'(pop_tx()));
        check_value("tx index high", 32'(index[15:8]), 32'(pop_tx()));
        check_value("tx index low", 32'(index[7:0]), 32'(pop_tx()));
        if (hdr == `CNN_HDR_READ) begin
            wait_tx_idle();
            for (i = 0; i < count; i++) begin
                repeat ($urandom % 4) @(posedge clk);
                @(posedge clk);
                rx_data <= file_data[i];
                rx_rdy  <= 1'b1;
                @(posedge clk);
                rx_rdy  <= 1'b0;
            end
        end else begin
            wait_tx_bytes(count, "output bytes");
            file_data.delete();
            for (i = 0; i < count; i++) begin
                file_data.push_back(pop_tx());
            end
        end
    endtask

    task automatic fill_operands(input bit zero_weights);
        int i;
        for (i = 0; i < `CNN_IN_LEN; i++) begin
            in_vec[i] = 8'($urandom);
        end
        for (i = 0; i < `CNN_IN_LEN * `CNN_OUT_LEN; i++) begin
            weights[i] = zero_weights ? 8'h00 : 8'($urandom);
        end
        for (i = 0; i < `CNN_OUT_LEN; i++) begin
            biases[i] = 8'($urandom);
        end
    endtask

    task automatic run_inference(input bit junk);
        int i;
        int base_done;
        base_done = done_count;
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value("busy after start", 1, 32'(busy));

        file_data.delete();
        for (i = 0; i < `CNN_IN_LEN; i++) begin
            file_data.push_back(in_vec[i]);
        end
        serve_transfer(`CNN_HDR_READ, `CNN_FILE_IN, `CNN_IN_LEN, junk);
        if (junk) begin
            // Second start while the run is in progress
            @(posedge clk);
            start <= 1'b1;
            @(posedge clk);
            start <= 1'b0;
        end

        file_data.delete();
        for (i = 0; i < `CNN_IN_LEN * `CNN_OUT_LEN; i++) begin
            file_data.push_back(weights[i]);
        end
        serve_transfer(`CNN_HDR_READ, `CNN_FILE_W, `CNN_IN_LEN * `CNN_OUT_LEN, junk);

        file_data.delete();
        for (i = 0; i < `CNN_OUT_LEN; i++) begin
            file_data.push_back(biases[i]);
        end
        serve_transfer(`CNN_HDR_READ, `CNN_FILE_BIAS, `CNN_OUT_LEN, junk);
        if (junk) begin
            send_junk(3);
        end

        serve_transfer(`CNN_HDR_WRITE, `CNN_FILE_OUT, `CNN_OUT_LEN, junk);
        for (i = 0; i < `CNN_OUT_LEN; i++) begin
            check_value($sformatf("output %0d", i), 32'(dense_sum(i)), 32'(file_data[i]));
        end

        wait_done();
        @(negedge clk);
        check_value("done pulses", base_done + 1, done_count);
        check_value("done", 0, 32'(done));
        check_value("busy after done", 0, 32'(busy));
        check_value("tx bytes left over", 0, tx_q.size());
    endtask

    task automatic test_reset_idle;
        int i;
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            check_value("tx_en", 0, 32'(tx_en));
            check_value("busy", 0, 32'(busy));
            check_value("done", 0, 32'(done));
        end
    endtask

    initial begin
        void'($urandom(58080));
        reset   = 1'b1;
        start   = 1'b0;
        rx_data = 8'h00;
        rx_rdy  = 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        test_reset_idle();

        fill_operands(1'b0);
        run_inference(1'b0);

        // Same operands, random transmitter delays
        slow_tx = 1'b1;
        run_inference(1'b0);

        fill_operands(1'b1);
        run_inference(1'b0);

        send_junk(4);
        fill_operands(1'b0);
        run_inference(1'b1);
        fill_operands(1'b0);
        run_inference(1'b0);

        $display("Errors: %0d, tx_en overlaps: %0d", errors, overlap_count);
        if (errors == 0 && overlap_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== cnn_engine.f ====
+incdir+rtl
rtl/cnn_pkg.sv
rtl/file_link.sv
rtl/scratch_ram.sv
rtl/dense_layer.sv
rtl/layer_sequencer.sv
rtl/cnn_engine.sv
tb/cnn_engine_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f cnn_engine.f --top-module cnn_engine_tb \
    -o cnn_engine_sim

out=$(./obj_dir/cnn_engine_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'TB PASSED'; then
    exit 0
fi
exit 1
